// ==== vlog.f ====
hw/zap_pkg.sv
hw/zap_decode.sv
hw/zap_execute.sv
hw/zap_result.sv
hw/zap_top.sv
verification/zap_tb_assert.sv
verification/zap_tb.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/10ps -f vlog.f --top-module zap_tb

run: compile
	@out="$$(./obj_dir/Vzap_tb)"; echo "$$out"; echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

// ==== verification/zap_tb.sv ====
`timescale 1ns/10ps

module zap_tb;

        localparam int NUM_ROWS    = 34;
        localparam int CYCLE_LIMIT = NUM_ROWS + 3 + 20;

        // ARM condition field values.
        localparam int EQ = 0;
        localparam int NE = 1;
        localparam int MI = 4;
        localparam int LS = 9;
        localparam int LT = 11;
        localparam int GT = 12;
        localparam int AL = 14;
        localparam int NV = 15;

        // ARM data-processing opcodes.
        localparam int AND = 0;
        localparam int EOR = 1;
        localparam int SUB = 2;
        localparam int ADD = 4;
        localparam int TST = 8;
        localparam int CMP = 10;
        localparam int ORR = 12;
        localparam int MOV = 13;
        localparam int BIC = 14;

        typedef struct packed {
                logic [31:0]    instr;
                logic           valid;
                logic           wr;
                logic [3:0]     idx;
                logic [31:0]    data;
                logic [3:0]     flags;  // N, Z, C, V.
        } row_t;

        logic           i_clk;
        logic           i_rst;
        logic [31:0]    i_instruction;
        logic           i_valid;
        logic           o_wr_valid;
        logic [3:0]     o_wr_index;
        logic [31:0]    o_wr_data;
        logic [3:0]     o_flags;

        row_t           rows [NUM_ROWS];
        int             row_count;
        int             cycles;
        int             tests_run;
        int             tests_failed;

        zap_top i_zap_top (
                .i_clk          (i_clk),
                .i_rst          (i_rst),
                .i_instruction  (i_instruction),
                .i_valid        (i_valid),
                .o_wr_valid     (o_wr_valid),
                .o_wr_index     (o_wr_index),
                .o_wr_data      (o_wr_data),
                .o_flags        (o_flags)
        );

        bind zap_top zap_tb_assert u_zap_tb_assert (
                .i_clk          (i_clk),
                .i_rst          (i_rst),
                .i_valid        (i_valid),
                .i_wr_valid     (o_wr_valid),
                .i_wr_index     (o_wr_index),
                .i_wr_data      (o_wr_data),
                .i_flags        (o_flags)
        );

        function automatic logic [31:0] dp_word(input int cond, input int imm, input int op,
                                                input int s, input int rn, input int rd,
                                                input logic [11:0] op2);
                dp_word = {cond[3:0], 2'b00, imm[0], op[3:0], s[0], rn[3:0], rd[3:0], op2};
        endfunction

        task automatic add_row(input logic [31:0] instr, input int valid, input int wr,
                               input int idx, input logic [31:0] data, input logic [3:0] flags);
                rows[row_count].instr = instr;
                rows[row_count].valid = valid[0];
                rows[row_count].wr    = wr[0];
                rows[row_count].idx   = idx[3:0];
                rows[row_count].data  = data;
                rows[row_count].flags = flags;
                row_count++;
        endtask

        // Columns: instruction, valid, write, index, data, NZCV after the instruction.
        task automatic build_table();
                add_row(dp_word(AL, 1, MOV, 0, 0, 1, 12'h4FF), 1, 1, 1, 32'hFF000000, 4'b0000);
                add_row(dp_word(AL, 1, MOV, 0, 0, 2, 12'h005), 1, 1, 2, 32'h00000005, 4'b0000);
                // Dependent chain, one per cycle.
                add_row(dp_word(AL, 0, ADD, 0, 1, 3, 12'h002), 1, 1, 3, 32'hFF000005, 4'b0000);
                add_row(dp_word(AL, 0, SUB, 0, 3, 4, 12'h002), 1, 1, 4, 32'hFF000000, 4'b0000);
                add_row(dp_word(AL, 0, AND, 0, 4, 5, 12'h003), 1, 1, 5, 32'hFF000000, 4'b0000);
                add_row(dp_word(AL, 0, ORR, 0, 5, 6, 12'h002), 1, 1, 6, 32'hFF000005, 4'b0000);
                add_row(dp_word(AL, 0, EOR, 0, 6, 7, 12'h001), 1, 1, 7, 32'h00000005, 4'b0000);
                add_row(dp_word(AL, 0, BIC, 0, 6, 8, 12'h007), 1, 1, 8, 32'hFF000000, 4'b0000);
                // Flag setting.
                add_row(dp_word(AL, 0, SUB, 1, 2, 9, 12'h002), 1, 1, 9, 32'h00000000, 4'b0110);
                add_row(dp_word(AL, 1, MOV, 0, 0, 10, 12'h47F), 1, 1, 10, 32'h7F000000, 4'b0110);
                add_row(dp_word(AL, 0, ADD, 1, 10, 11, 12'h00A), 1, 1, 11, 32'hFE000000, 4'b1001);
                add_row(dp_word(AL, 1, CMP, 1, 2, 0, 12'h005), 1, 0, 0, 32'h0, 4'b0110);
                add_row(dp_word(AL, 1, ADD, 0, 2, 12, 12'h003), 1, 1, 12, 32'h00000008, 4'b0110);
                // Conditional execution.
                add_row(dp_word(EQ, 1, ADD, 0, 2, 13, 12'h001), 1, 1, 13, 32'h00000006, 4'b0110);
                add_row(dp_word(NE, 1, MOV, 0, 0, 13, 12'h055), 1, 0, 0, 32'h0, 4'b0110);
                add_row(dp_word(AL, 0, CMP, 1, 1, 0, 12'h002), 1, 0, 0, 32'h0, 4'b1010);
                add_row(dp_word(MI, 1, SUB, 1, 2, 14, 12'h005), 1, 1, 14, 32'h00000000, 4'b0110);
                add_row(dp_word(MI, 0, ADD, 1, 1, 14, 12'h001), 1, 0, 0, 32'h0, 4'b0110);
                add_row(dp_word(NV, 1, MOV, 0, 0, 0, 12'h001), 1, 0, 0, 32'h0, 4'b0110);
                add_row(dp_word(LS, 1, ADD, 1, 2, 0, 12'h002), 1, 1, 0, 32'h00000007, 4'b0000);
                add_row(dp_word(GT, 1, MOV, 0, 0, 15, 12'h009), 1, 1, 15, 32'h00000009, 4'b0000);
                // Unsupported encodings become bubbles.
                add_row(dp_word(AL, 0, ADD, 1, 1, 1, 12'h082), 1, 0, 0, 32'h0, 4'b0000);
                add_row(32'hE5923000, 1, 0, 0, 32'h0, 4'b0000); // LDR r3, [r2].
                add_row(dp_word(AL, 0, TST, 1, 1, 0, 12'h002), 1, 0, 0, 32'h0, 4'b0000);
                // Gaps on i_valid.
                add_row(dp_word(AL, 1, ADD, 0, 2, 4, 12'h001), 0, 0, 0, 32'h0, 4'b0000);
                add_row(dp_word(AL, 1, MOV, 0, 0, 4, 12'h011), 1, 1, 4, 32'h00000011, 4'b0000);
                add_row(dp_word(AL, 1, MOV, 0, 0, 9, 12'h033), 0, 0, 0, 32'h0, 4'b0000);
                add_row(32'h0, 0, 0, 0, 32'h0, 4'b0000);
                add_row(32'h0, 0, 0, 0, 32'h0, 4'b0000);
                add_row(dp_word(AL, 0, ADD, 0, 4, 5, 12'h002), 1, 1, 5, 32'h00000016, 4'b0000);
                add_row(dp_word(AL, 1, ADD, 1, 5, 6, 12'h001), 1, 1, 6, 32'h00000017, 4'b0000);
                add_row(dp_word(AL, 1, SUB, 1, 6, 7, 12'h020), 1, 1, 7, 32'hFFFFFFF7, 4'b1000);
                add_row(32'h0, 0, 0, 0, 32'h0, 4'b1000);
                add_row(dp_word(LT, 0, MOV, 0, 0, 8, 12'h007), 1, 1, 8, 32'hFFFFFFF7, 4'b1000);
        endtask

        task automatic check_reset();
                logic bad;
                bad = 1'b0;
                if (o_wr_valid !== 1'b0) begin
                        $display("Mismatch o_wr_valid after reset: got %h expected %h",
                                 o_wr_valid, 1'b0);
                        bad = 1'b1;
                end
                if (o_flags !== 4'h0) begin
                        $display("Mismatch o_flags after reset: got %h expected %h", o_flags, 4'h0);
                        bad = 1'b1;
                end
                tests_run++;
                if (bad) begin
                        tests_failed++;
                        $display("reset values failed");
                end else begin
                        $display("reset values passed");
                end
        endtask

        task automatic check_row(input int r);
                logic bad;
                bad = 1'b0;
                if (o_wr_valid !== rows[r].wr) begin
                        $display("Mismatch o_wr_valid row %0d: got %h expected %h",
                                 r, o_wr_valid, rows[r].wr);
                        bad = 1'b1;
                end
                if (rows[r].wr && (o_wr_index !== rows[r].idx)) begin
                        $display("Mismatch o_wr_index row %0d: got %h expected %h",
                                 r, o_wr_index, rows[r].idx);
                        bad = 1'b1;
                end
                if (rows[r].wr && (o_wr_data !== rows[r].data)) begin
                        $display("Mismatch o_wr_data row %0d: got %h expected %h",
                                 r, o_wr_data, rows[r].data);
                        bad = 1'b1;
                end
                if (o_flags !== rows[r].flags) begin
                        $display("Mismatch o_flags row %0d: got %h expected %h",
                                 r, o_flags, rows[r].flags);
                        bad = 1'b1;
                end
                tests_run++;
                if (bad) begin
                        tests_failed++;
                        $display("row %0d failed", r);
                end else begin
                        $display("row %0d passed", r);
                end
        endtask

        initial begin
                i_clk = 1'b0;
                forever #2 i_clk = ~i_clk;
        end

        initial begin
                cycles = 0;
                while (cycles < CYCLE_LIMIT) begin
                        @(posedge i_clk);
                        cycles++;
                end
                $display("Timeout after %0d cycles without finishing the table", cycles);
                $display("tests failed");
                $finish;
        end

        initial begin
                i_rst         = 1'b1;
                i_valid       = 1'b0;
                i_instruction = '0;
                row_count     = 0;
                tests_run     = 0;
                tests_failed  = 0;
                build_table();
                repeat (2) @(posedge i_clk);
                @(negedge i_clk);
                i_rst = 1'b0;
                check_reset();
                // Row r is driven here and checked three falling edges later.
                for (int step = 0; step < NUM_ROWS + 3; step++) begin
                        if (step >= 3) begin
                                check_row(step - 3);
                        end
                        if (step < NUM_ROWS) begin
                                i_instruction = rows[step].instr;
                                i_valid       = rows[step].valid;
                        end else begin
                                i_instruction = '0;
                                i_valid       = 1'b0;
                        end
                        @(negedge i_clk);
                end
                $display("Summary: %0d checked, %0d passed, %0d failed, %0d assertion errors",
                         tests_run, tests_run - tests_failed, tests_failed,
                         i_zap_top.u_zap_tb_assert.fail_count);
                if (tests_failed == 0 && i_zap_top.u_zap_tb_assert.fail_count == 0) begin
                        $display("all tests passed");
                end else begin
                        $display("tests failed");
                end
                $finish;
        end

endmodule

// ==== verification/zap_tb_assert.sv ====
`timescale 1ns/10ps

module zap_tb_assert (
        input logic             i_clk,
        input logic             i_rst,
        input logic             i_valid,
        input logic             i_wr_valid,
        input logic [3:0]       i_wr_index,
        input logic [31:0]      i_wr_data,
        input logic [3:0]       i_flags
);

        int fail_count = 0;

        wr_low_after_reset: assert property (@(posedge i_clk) i_rst |=> !i_wr_valid)
                else begin
                        $error("write strobe high in the cycle after reset");
                        fail_count++;
                end

        // Index and data are only qualified by the strobe.
        wr_payload_known: assert property (@(posedge i_clk) disable iff (i_rst)
                        i_wr_valid |-> !$isunknown({i_wr_index, i_wr_data}))
                else begin
                        $error("write index or data unknown while strobe is high");
                        fail_count++;
                end

        flags_hold_after_reset: assert property (@(posedge i_clk)
                        $fell(i_rst) |=> $stable(i_flags))
                else begin
                        $error("flags changed in the cycle after reset");
                        fail_count++;
                end

        // Three idle edges leave nothing in flight.
        no_wr_when_idle: assert property (@(posedge i_clk) disable iff (i_rst)
                        (!$past(i_valid, 1) && !$past(i_valid, 2) && !$past(i_valid, 3))
                        |-> !i_wr_valid)
                else begin
                        $error("write strobe high with no instruction in flight");
                        fail_count++;
                end

endmodule

// ==== hw/zap_top.sv ====
`timescale 1ns/10ps

module zap_top (
        input  logic            i_clk,
        input  logic            i_rst,
        input  logic [31:0]     i_instruction,
        input  logic            i_valid,
        output logic            o_wr_valid,
        output logic [3:0]      o_wr_index,
        output logic [31:0]     o_wr_data,
        output logic [3:0]      o_flags         // N, Z, C, V.
);

        zap_pkg::decoded_t                      dec;
        zap_pkg::result_t                       exe_res;
        zap_pkg::flags_t                        exe_flags;
        logic [zap_pkg::REG_IDX_W-1:0]          rd_idx_a;
        logic [zap_pkg::REG_IDX_W-1:0]          rd_idx_b;
        logic [zap_pkg::XLEN-1:0]               rd_data_a;
        logic [zap_pkg::XLEN-1:0]               rd_data_b;

        zap_decode u_zap_decode (
                .i_clk          (i_clk),
                .i_rst          (i_rst),
                .i_instruction  (i_instruction),
                .i_valid        (i_valid),
                .o_dec          (dec)
        );

        zap_execute u_zap_execute (
                .i_clk          (i_clk),
                .i_rst          (i_rst),
                .i_dec          (dec),
                .o_rd_idx_a     (rd_idx_a),
                .o_rd_idx_b     (rd_idx_b),
                .i_rd_data_a    (rd_data_a),
                .i_rd_data_b    (rd_data_b),
                .o_res          (exe_res),
                .o_flags        (exe_flags)
        );

        zap_result u_zap_result (
                .i_clk          (i_clk),
                .i_rst          (i_rst),
                .i_res          (exe_res),
                .i_flags        (exe_flags),
                .i_rd_idx_a     (rd_idx_a),
                .i_rd_idx_b     (rd_idx_b),
                .o_rd_data_a    (rd_data_a),
                .o_rd_data_b    (rd_data_b),
                .o_wr_valid     (o_wr_valid),
                .o_wr_index     (o_wr_index),
                .o_wr_data      (o_wr_data),
                .o_flags        (o_flags)
        );

endmodule

// ==== hw/zap_result.sv ====
`timescale 1ns/10ps

module zap_result (
        input  logic                            i_clk,
        input  logic                            i_rst,
        input  zap_pkg::result_t                i_res,
        input  zap_pkg::flags_t                 i_flags,
        input  logic [zap_pkg::REG_IDX_W-1:0]   i_rd_idx_a,
        input  logic [zap_pkg::REG_IDX_W-1:0]   i_rd_idx_b,
        output logic [zap_pkg::XLEN-1:0]        o_rd_data_a,
        output logic [zap_pkg::XLEN-1:0]        o_rd_data_b,
        output logic                            o_wr_valid,
        output logic [zap_pkg::REG_IDX_W-1:0]   o_wr_index,
        output logic [zap_pkg::XLEN-1:0]        o_wr_data,
        output zap_pkg::flags_t                 o_flags
);

        localparam int NUM_REGS = 2 ** zap_pkg::REG_IDX_W;

        logic [zap_pkg::XLEN-1:0] regs [NUM_REGS];

        // Asynchronous read ports.
        assign o_rd_data_a = regs[i_rd_idx_a];
        assign o_rd_data_b = regs[i_rd_idx_b];

        always_ff @(posedge i_clk) begin
                if (i_rst) begin
                        for (int i = 0; i < NUM_REGS; i++) begin
                                regs[i] <= '0;
                        end
                end else if (i_res.valid) begin
                        regs[i_res.rd] <= i_res.data;
                end
        end

        always_ff @(posedge i_clk) begin
                if (i_rst) begin
                        o_wr_valid <= 1'b0;
                        o_flags    <= '0;
                end else begin
                        o_wr_valid <= i_res.valid;
                        o_flags    <= i_flags;
                end
        end

        // Write payload, qualified by o_wr_valid.
        always_ff @(posedge i_clk) begin
                o_wr_index <= i_res.rd;
                o_wr_data  <= i_res.data;
        end

endmodule

// ==== hw/zap_execute.sv ====
`timescale 1ns/10ps

module zap_execute (
        input  logic                            i_clk,
        input  logic                            i_rst,
        input  zap_pkg::decoded_t               i_dec,
        output logic [zap_pkg::REG_IDX_W-1:0]   o_rd_idx_a,
        output logic [zap_pkg::REG_IDX_W-1:0]   o_rd_idx_b,
        input  logic [zap_pkg::XLEN-1:0]        i_rd_data_a,
        input  logic [zap_pkg::XLEN-1:0]        i_rd_data_b,
        output zap_pkg::result_t                o_res,
        output zap_pkg::flags_t                 o_flags
);

        localparam int XLEN = zap_pkg::XLEN;

        zap_pkg::result_t       res_q;
        zap_pkg::result_t       res_nxt;
        zap_pkg::flags_t        flags_q;
        zap_pkg::flags_t        flags_nxt;

        logic [XLEN-1:0]        op_a;
        logic [XLEN-1:0]        op_b;
        logic [XLEN-1:0]        rm_val;
        logic [XLEN-1:0]        imm_ext;
        logic [2*XLEN-1:0]      imm_rot;
        logic [4:0]             rot_amt;
        logic                   sub_op;
        logic [XLEN-1:0]        add_b;
        logic [XLEN:0]          sum;
        logic [XLEN-1:0]        alu_out;
        logic                   exec;

        function automatic logic cond_pass(zap_pkg::cond_e cc, zap_pkg::flags_t f);
                case (cc)
                        zap_pkg::COND_EQ: return f.z;
                        zap_pkg::COND_NE: return !f.z;
                        zap_pkg::COND_CS: return f.c;
                        zap_pkg::COND_CC: return !f.c;
                        zap_pkg::COND_MI: return f.n;
                        zap_pkg::COND_PL: return !f.n;
                        zap_pkg::COND_VS: return f.v;
                        zap_pkg::COND_VC: return !f.v;
                        zap_pkg::COND_HI: return f.c && !f.z;
                        zap_pkg::COND_LS: return !f.c || f.z;
                        zap_pkg::COND_GE: return f.n == f.v;
                        zap_pkg::COND_LT: return f.n != f.v;
                        zap_pkg::COND_GT: return !f.z && (f.n == f.v);
                        zap_pkg::COND_LE: return f.z || (f.n != f.v);
                        zap_pkg::COND_AL: return 1'b1;
                        default:          return 1'b0;
                endcase
        endfunction

        assign o_rd_idx_a = i_dec.rn;
        assign o_rd_idx_b = i_dec.rm;

        // Only the instruction one ahead is not yet in the register file.
        assign op_a   = (res_q.valid && res_q.rd == i_dec.rn) ? res_q.data : i_rd_data_a;
        assign rm_val = (res_q.valid && res_q.rd == i_dec.rm) ? res_q.data : i_rd_data_b;

        // Immediate rotated right by twice the rotate field.
        assign imm_ext = {{(XLEN-zap_pkg::IMM_W){1'b0}}, i_dec.imm};
        assign rot_amt = {i_dec.rot, 1'b0};
        assign imm_rot = {imm_ext, imm_ext} >> rot_amt;
        assign op_b    = i_dec.use_imm ? imm_rot[XLEN-1:0] : rm_val;

        // Subtract as a + ~b + 1, so carry out is not-borrow.
        assign sub_op = (i_dec.op == zap_pkg::ALU_SUB) || (i_dec.op == zap_pkg::ALU_CMP);
        assign add_b  = sub_op ? ~op_b : op_b;
        assign sum    = {1'b0, op_a} + {1'b0, add_b} + {{XLEN{1'b0}}, sub_op};

        always_comb begin
                flags_nxt = flags_q;
                case (i_dec.op)
                        zap_pkg::ALU_AND: alu_out = op_a & op_b;
                        zap_pkg::ALU_EOR: alu_out = op_a ^ op_b;
                        zap_pkg::ALU_ORR: alu_out = op_a | op_b;
                        zap_pkg::ALU_MOV: alu_out = op_b;
                        zap_pkg::ALU_BIC: alu_out = op_a & ~op_b;
                        default:          alu_out = sum[XLEN-1:0];
                endcase
                flags_nxt.n = alu_out[XLEN-1];
                flags_nxt.z = (alu_out == '0);
                if (i_dec.op == zap_pkg::ALU_ADD || sub_op) begin
                        flags_nxt.c = sum[XLEN];
                        flags_nxt.v = (op_a[XLEN-1] == add_b[XLEN-1]) &&
                                      (sum[XLEN-1] != op_a[XLEN-1]);
                end
        end

        assign exec = i_dec.valid && cond_pass(i_dec.cond, flags_q);

        always_comb begin
                res_nxt.valid = exec && i_dec.writes_rd;
                res_nxt.rd    = i_dec.rd;
                res_nxt.data  = alu_out;
        end

        always_ff @(posedge i_clk) begin
                if (i_rst) begin
                        res_q   <= '0;
                        flags_q <= '0;
                end else begin
                        res_q <= res_nxt;
                        if (exec && i_dec.set_flags) begin
                                flags_q <= flags_nxt;
                        end
                end
        end

        assign o_res   = res_q;
        assign o_flags = flags_q;

endmodule

// ==== hw/zap_decode.sv ====
`timescale 1ns/10ps

module zap_decode (
        input  logic                    i_clk,
        input  logic                    i_rst,
        input  logic [31:0]             i_instruction,
        input  logic                    i_valid,
        output zap_pkg::decoded_t       o_dec
);

        zap_pkg::decoded_t      dec_nxt;
        zap_pkg::decoded_t      dec_q;
        logic                   class_ok;
        logic                   op_ok;
        logic                   form_ok;
        logic                   s_ok;
        logic                   is_cmp;

        // Data-processing class has bits 27:26 clear.
        assign class_ok = (i_instruction[27:26] == 2'b00);

        always_comb begin
                case (i_instruction[24:21])
                        zap_pkg::ALU_AND,
                        zap_pkg::ALU_EOR,
                        zap_pkg::ALU_SUB,
                        zap_pkg::ALU_ADD,
                        zap_pkg::ALU_CMP,
                        zap_pkg::ALU_ORR,
                        zap_pkg::ALU_MOV,
                        zap_pkg::ALU_BIC: op_ok = 1'b1;
                        default:          op_ok = 1'b0;
                endcase
        end

        assign is_cmp = (i_instruction[24:21] == zap_pkg::ALU_CMP);

        // No shifter, so a register operand must be unshifted.
        assign form_ok = i_instruction[25] || (i_instruction[11:4] == 8'h00);

        // CMP without S is an MSR/MRS encoding.
        assign s_ok = !is_cmp || i_instruction[20];

        always_comb begin
                dec_nxt.valid     = i_valid && class_ok && op_ok && form_ok && s_ok;
                dec_nxt.cond      = zap_pkg::cond_e'(i_instruction[31:28]);
                dec_nxt.op        = zap_pkg::alu_op_e'(i_instruction[24:21]);
                dec_nxt.set_flags = i_instruction[20];
                dec_nxt.writes_rd = !is_cmp;
                dec_nxt.rn        = i_instruction[19:16];
                dec_nxt.rd        = i_instruction[15:12];
                dec_nxt.rm        = i_instruction[3:0];
                dec_nxt.use_imm   = i_instruction[25];
                dec_nxt.rot       = i_instruction[11:8];
                dec_nxt.imm       = i_instruction[7:0];
        end

        always_ff @(posedge i_clk) begin
                if (i_rst) begin
                        dec_q <= '0;
                end else begin
                        dec_q <= dec_nxt; // Bubble when valid is clear.
                end
        end

        assign o_dec = dec_q;

endmodule

// ==== hw/zap_pkg.sv ====
package zap_pkg;

        localparam int XLEN      = 32;
        localparam int REG_IDX_W = 4;
        localparam int IMM_W     = 8;
        localparam int ROT_W     = 4;

        // ARM condition field encodings.
        typedef enum logic [3:0] {
                COND_EQ = 4'h0,
                COND_NE = 4'h1,
                COND_CS = 4'h2,
                COND_CC = 4'h3,
                COND_MI = 4'h4,
                COND_PL = 4'h5,
                COND_VS = 4'h6,
                COND_VC = 4'h7,
                COND_HI = 4'h8,
                COND_LS = 4'h9,
                COND_GE = 4'hA,
                COND_LT = 4'hB,
                COND_GT = 4'hC,
                COND_LE = 4'hD,
                COND_AL = 4'hE,
                COND_NV = 4'hF  // Never executes.
        } cond_e;

        // Only the supported data-processing opcodes.
        typedef enum logic [3:0] {
                ALU_AND = 4'h0,
                ALU_EOR = 4'h1,
                ALU_SUB = 4'h2,
                ALU_ADD = 4'h4,
                ALU_CMP = 4'hA,
                ALU_ORR = 4'hC,
                ALU_MOV = 4'hD,
                ALU_BIC = 4'hE
        } alu_op_e;

        typedef struct packed {
                logic n;
                logic z;
                logic c;
                logic v;
        } flags_t;

        typedef struct packed {
                logic                   valid;
                cond_e                  cond;
                alu_op_e                op;
                logic                   set_flags;
                logic                   writes_rd;  // Clear for CMP.
                logic [REG_IDX_W-1:0]   rd;
                logic [REG_IDX_W-1:0]   rn;
                logic [REG_IDX_W-1:0]   rm;
                logic                   use_imm;
                logic [IMM_W-1:0]       imm;
                logic [ROT_W-1:0]       rot;
        } decoded_t;

        typedef struct packed {
                logic                   valid;
                logic [REG_IDX_W-1:0]   rd;
                logic [XLEN-1:0]        data;
        } result_t;

endpackage
